/* run.sh */
#!/usr/bin/env bash
# compile and run with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_spike_conv \
    -f tb.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "sim passed" ||
{ echo "simulation did not pass"; exit 1; }

/* tb.f */
verilog/snn_pkg.sv
verilog/psum_ram.sv
verilog/psum_ram_arbiter.sv
verilog/host_regs.sv
verilog/psum_callback.sv
verilog/lif_row.sv
verilog/spike_conv_top.sv
test/clk_gen.sv
test/tb_spike_conv.sv

/* test/clk_gen.sv */
`timescale 1ns/1ns
module clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 8
) (
    output logic s_clk,
    output logic s_rst
);

    initial begin
        s_clk = 1'b0;
        forever #(PERIOD / 2) s_clk = ~s_clk;
    end

    // release just after an edge
    initial begin
        s_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge s_clk);
        #1 s_rst = 1'b0;
    end

endmodule

/* test/tb_spike_conv.sv */
`timescale 1ns/1ns
module tb_spike_conv;

    logic                           s_clk;
    logic                           s_rst;
    logic [snn_pkg::AXI_AW-1:0]     awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [snn_pkg::WORD_W-1:0]     wdata;
    logic [3:0]                     wstrb;
    logic                           wvalid;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [snn_pkg::AXI_AW-1:0]     araddr;
    logic                           arvalid;
    logic                           arready;
    logic [snn_pkg::WORD_W-1:0]     rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;
    logic                           spike_valid;
    logic [snn_pkg::TIME_STEPS-1:0] spike_bits;
    logic                           done;

    // host side copy of the psum ram
    logic [snn_pkg::WORD_W-1:0]     psum_img [256];
    logic [snn_pkg::TIME_STEPS-1:0] spike_q [$];
    int                             cycle = 0;
    int                             done_cnt = 0;
    int                             done_base;
    int                             first_spike;
    int                             last_spike;
    int                             done_cyc;
    int                             start_cyc;
    int                             b_cyc;
    int                             cur_img;
    int                             cur_scale;
    logic [snn_pkg::MEM_W-1:0]      cur_thrd;
    logic [snn_pkg::PSUM_W-1:0]     cur_bias;

    clk_gen u_clk_gen (.s_clk(s_clk), .s_rst(s_rst));

    spike_conv_top #(.DEPTH(256)) uut (.*);

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
        if (spike_valid) begin
            if (spike_q.size() == 0) begin
                first_spike = cycle;
            end
            last_spike = cycle;
            spike_q.push_back(spike_bits);
        end
        if (done) begin
            done_cyc = cycle;
            done_cnt <= done_cnt + 1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // expected spikes for one word under the current settings
    function automatic logic [snn_pkg::TIME_STEPS-1:0] lif_ref(input logic [31:0] word);
        logic signed [15:0]             bext;
        logic signed [15:0]             mem;
        logic signed [15:0]             p;
        logic [snn_pkg::TIME_STEPS-1:0] bits;
        bext = {{8{cur_bias[7]}}, cur_bias};
        for (int k = 0; k < cur_scale; k++) begin
            bext = bext << 1;
        end
        mem = '0;
        for (int t = 0; t < snn_pkg::TIME_STEPS; t++) begin
            p = {{8{word[8*t+7]}}, word[8*t +: 8]};
            mem = mem + p + bext;
            bits[t] = mem >= $signed(cur_thrd);
            if (bits[t]) begin
                mem = '0;
            end
        end
        return bits;
    endfunction

    function automatic int budget(input int img, input int acc, input int words);
        return img * img + 8 * acc + 2 * words + 40;
    endfunction

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge s_clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge s_clk);
            if (awvalid && awready) aw_done = 1'b1;
            if (wvalid && wready) w_done = 1'b1;
            #1;
            if (aw_done) awvalid = 1'b0;
            if (w_done) wvalid = 1'b0;
        end
        @(posedge s_clk);
        while (!bvalid) @(posedge s_clk);
        b_cyc = cycle;
        assert (bresp == 2'b00)
            else fail_now($sformatf("[FAIL] bresp exp 0 got %h", bresp));
        #1 bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge s_clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(posedge s_clk);
        while (!arready) @(posedge s_clk);
        #1 arvalid = 1'b0;
        @(posedge s_clk);
        while (!rvalid) @(posedge s_clk);
        data = rdata;
        assert (rresp == 2'b00)
            else fail_now($sformatf("[FAIL] rresp exp 0 got %h", rresp));
        #1 rready = 1'b0;
    endtask

    task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        axi_read(addr, got);
        assert (got == exp)
            else fail_now($sformatf("[FAIL] rdata @%h exp %h got %h", addr, exp, got));
    endtask

    task automatic load_psum(input int idx, input logic [31:0] word);
        psum_img[idx] = word;
        axi_write(snn_pkg::PSUM_WIN + 12'(4 * idx), word);
    endtask

    task automatic configure(input int img, input logic [15:0] thrd,
                             input logic [7:0] bias, input int scale);
        cur_img   = img;
        cur_thrd  = thrd;
        cur_bias  = bias;
        cur_scale = scale;
        axi_write(snn_pkg::REG_IMG, 32'(img));
        axi_write(snn_pkg::REG_THRD, {16'h0000, thrd});
        axi_write(snn_pkg::REG_BIAS, {20'h00000, 4'(scale), bias});
    endtask

    task automatic start_run();
        spike_q.delete();
        done_base = done_cnt;
        axi_write(snn_pkg::REG_CTRL, 32'h1);
        start_cyc = b_cyc;
    endtask

    task automatic check_run();
        int                             n;
        logic [snn_pkg::TIME_STEPS-1:0] exp;
        n = (cur_img - 2) * (cur_img - 2);
        while (done_cnt == done_base) @(posedge s_clk);
        assert (spike_q.size() == n)
            else fail_now($sformatf("run gave %0d spike words, wanted %0d", spike_q.size(), n));
        assert (first_spike - start_cyc == cur_scale + 4)
            else fail_now("first spike_valid came at the wrong cycle after start");
        assert (done_cyc == last_spike + 1)
            else fail_now("done did not follow the last spike_valid");
        for (int i = 0; i < n; i++) begin
            exp = lif_ref(psum_img[i]);
            assert (spike_q[i] == exp)
                else fail_now($sformatf("[FAIL] spike_bits word %0d exp %h got %h",
                                        i, exp, spike_q[i]));
        end
    endtask

    task automatic regs_readback();
        check_reg(snn_pkg::REG_STATUS, 32'h0);
        configure(6, 16'h0123, 8'hA7, 5);
        check_reg(snn_pkg::REG_IMG, 32'h6);
        check_reg(snn_pkg::REG_THRD, 32'h0123);
        check_reg(snn_pkg::REG_BIAS, 32'h5A7);
        // window reads are not backed by the ram
        check_reg(snn_pkg::PSUM_WIN, 32'h0);
    endtask

    task automatic basic_run();
        for (int i = 0; i < 16; i++) begin
            load_psum(i, $urandom);
        end
        configure(6, 16'd20, 8'h00, 0);
        start_run();
        check_run();
        check_reg(snn_pkg::REG_STATUS, 32'h2);
    endtask

    task automatic bias_run();
        for (int i = 0; i < 16; i++) begin
            load_psum(i, 32'h0);
        end
        // -5 shifted three times gives -40, never reaching -30
        configure(6, 16'hFFE2, 8'hFB, 3);
        start_run();
        check_run();
        check_reg(snn_pkg::REG_STATUS, 32'h2);
    endtask

    task automatic threshold_runs();
        load_psum(0, 32'h07040606);
        load_psum(1, 32'h0A0A0A0A);
        load_psum(2, 32'h00000000);
        load_psum(3, 32'hF614FB09);
        configure(4, 16'd10, 8'h00, 0);
        start_run();
        check_run();
        assert (spike_q[0] == 4'b1010)
            else fail_now($sformatf("[FAIL] spike_bits word 0 exp a got %h", spike_q[0]));
        // negative threshold, signed compare
        load_psum(0, 32'h0502F7FB);
        configure(4, 16'hFFF8, 8'h00, 0);
        start_run();
        check_run();
        assert (spike_q[0] == 4'b1101)
            else fail_now($sformatf("[FAIL] spike_bits word 0 exp d got %h", spike_q[0]));
    endtask

    task automatic contention_run();
        for (int i = 0; i < 256; i++) begin
            load_psum(i, $urandom);
        end
        configure(16, 16'd30, 8'h02, 1);
        start_run();
        // these stall behind the reads, all beyond the 14x14 map
        for (int k = 0; k < 4; k++) begin
            load_psum(200 + k, $urandom);
        end
        check_run();
        configure(18, 16'd30, 8'h02, 1);
        start_run();
        check_run();
    endtask

    initial begin : watchdog
        int limit;
        limit = 200 + budget(0, 8, 0) + 2 * budget(6, 21, 16) + 2 * budget(4, 8, 4)
              + budget(16, 264, 196) + budget(18, 4, 256);
        repeat (limit) @(posedge s_clk);
        fail_now($sformatf("timeout, tests did not finish within %0d cycles", limit));
    end

    initial begin
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(33031));
        @(negedge s_rst);
        regs_readback();
        basic_run();
        bias_run();
        threshold_runs();
        contention_run();
        $display("sim passed");
        $finish;
    end

endmodule

/* verilog/host_regs.sv */
`timescale 1ns/1ns
module host_regs #(
    parameter int DEPTH = 256
) (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic [snn_pkg::AXI_AW-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [snn_pkg::WORD_W-1:0]  wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [snn_pkg::AXI_AW-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [snn_pkg::WORD_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        host_req,
    output logic [snn_pkg::ADDR_W-1:0]  host_addr,
    output logic [snn_pkg::WORD_W-1:0]  host_wdata,
    input  logic                        host_gnt,
    output logic                        start,
    output logic [7:0]                  img_size,
    output logic [snn_pkg::MEM_W-1:0]   lif_thrd,
    output logic [snn_pkg::PSUM_W-1:0]  bias,
    output logic [3:0]                  bias_scale,
    input  logic                        done
);

    logic                        aw_full;
    logic                        w_full;
    logic [snn_pkg::AXI_AW-1:0]  aw_addr;
    logic [snn_pkg::WORD_W-1:0]  w_data;
    logic [3:0]                  w_strb;
    logic [snn_pkg::WORD_W-1:0]  w_mask;
    logic [snn_pkg::WORD_W-1:0]  wr_word;
    logic [snn_pkg::AXI_AW-1:0]  win_off;
    logic                        in_win;
    logic                        wr_go;
    logic                        busy;
    logic                        done_flag;

    function automatic logic [snn_pkg::WORD_W-1:0] reg_word(
        input logic [snn_pkg::AXI_AW-1:0] a
    );
        logic [snn_pkg::WORD_W-1:0] v;
        v = '0;
        case (a)
            snn_pkg::REG_IMG:    v[7:0] = img_size;
            snn_pkg::REG_THRD:   v[snn_pkg::MEM_W-1:0] = lif_thrd;
            snn_pkg::REG_BIAS:   v[11:0] = {bias_scale, bias};
            snn_pkg::REG_STATUS: v[1:0] = {done_flag, busy};
            default:             v = '0;
        endcase
        return v;
    endfunction

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // both halves of the write present and no response outstanding
    assign wr_go   = aw_full & w_full & ~bvalid & ~host_req;
    assign win_off = aw_addr - snn_pkg::PSUM_WIN;
    assign in_win  = aw_addr >= snn_pkg::PSUM_WIN &&
                     int'(aw_addr) < int'(snn_pkg::PSUM_WIN) + 4 * DEPTH;

    assign w_mask  = {{8{w_strb[3]}}, {8{w_strb[2]}}, {8{w_strb[1]}}, {8{w_strb[0]}}};
    assign wr_word = (reg_word(aw_addr) & ~w_mask) | (w_data & w_mask);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            bvalid     <= 1'b0;
            host_req   <= 1'b0;
            start      <= 1'b0;
            img_size   <= '0;
            lif_thrd   <= '0;
            bias       <= '0;
            bias_scale <= '0;
        end else begin
            start   <= 1'b0;
            awready <= awvalid & ~awready & ~aw_full;
            wready  <= wvalid & ~wready & ~w_full;
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // psum write answered once the arbiter takes it
            if (host_req && host_gnt) begin
                host_req <= 1'b0;
                bvalid   <= 1'b1;
            end
            if (wr_go) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                if (in_win) begin
                    host_req <= 1'b1;
                end else begin
                    bvalid <= 1'b1;
                    case (aw_addr)
                        snn_pkg::REG_CTRL: start <= wr_word[0];
                        snn_pkg::REG_IMG:  img_size <= wr_word[7:0];
                        snn_pkg::REG_THRD: lif_thrd <= wr_word[snn_pkg::MEM_W-1:0];
                        snn_pkg::REG_BIAS: begin
                            bias       <= wr_word[7:0];
                            bias_scale <= wr_word[11:8];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
        if (wr_go) begin
            host_addr  <= win_off[snn_pkg::ADDR_W+1:2];
            host_wdata <= w_data;
        end
        if (arvalid && arready) begin
            rdata <= reg_word(araddr);
        end
    end

    // read channel and run status
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            arready <= arvalid & ~arready & ~rvalid;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

endmodule

/* verilog/lif_row.sv */
`timescale 1ns/1ns
module lif_row (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           psum_valid,
    input  logic [snn_pkg::WORD_W-1:0]     psum_word,
    input  logic [snn_pkg::MEM_W-1:0]      bias_ext,
    input  logic [snn_pkg::MEM_W-1:0]      thrd,
    output logic                           spike_valid,
    output logic [snn_pkg::TIME_STEPS-1:0] spike_bits
);

    logic [snn_pkg::TIME_STEPS-1:0] fire;

    // membrane integrates step by step, reset to zero after each spike
    always_comb begin
        logic signed [snn_pkg::MEM_W-1:0] mem;
        logic signed [snn_pkg::MEM_W-1:0] step;
        mem = '0;
        for (int t = 0; t < snn_pkg::TIME_STEPS; t++) begin
            step = {{(snn_pkg::MEM_W - snn_pkg::PSUM_W)
                     {psum_word[t * snn_pkg::PSUM_W + snn_pkg::PSUM_W - 1]}},
                    psum_word[t * snn_pkg::PSUM_W +: snn_pkg::PSUM_W]};
            mem = mem + step + $signed(bias_ext);
            if (mem >= $signed(thrd)) begin
                fire[t] = 1'b1;
                mem     = '0;
            end else begin
                fire[t] = 1'b0;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            spike_valid <= 1'b0;
        end else begin
            spike_valid <= psum_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (psum_valid) begin
            spike_bits <= fire;
        end
    end

endmodule

/* verilog/psum_callback.sv */
`timescale 1ns/1ns
module psum_callback #(
    parameter int DEPTH = 256
) (
    input  logic                       s_clk,
    input  logic                       s_rst,
    input  logic                       start,
    input  logic [7:0]                 img_size,
    input  logic [snn_pkg::MEM_W-1:0]  lif_thrd,
    input  logic [snn_pkg::PSUM_W-1:0] bias,
    input  logic [3:0]                 bias_scale,
    output logic                       rd_req,
    output logic [snn_pkg::ADDR_W-1:0] rd_addr,
    input  logic                       rd_gnt,
    input  logic [snn_pkg::WORD_W-1:0] rd_data,
    input  logic                       rd_data_valid,
    output logic                       psum_valid,
    output logic [snn_pkg::WORD_W-1:0] psum_word,
    output logic [snn_pkg::MEM_W-1:0]  bias_ext,
    output logic [snn_pkg::MEM_W-1:0]  thrd,
    output logic                       done
);

    // output map side length, img_size - 2
    logic [7:0]  side;
    logic [15:0] total;
    logic [3:0]  scale_cnt;
    logic        shifting;
    logic        busy;
    logic [7:0]  pos_x;
    logic [7:0]  pos_y;
    logic        last_pos;
    logic [15:0] ret_cnt;
    logic        last_ret;

    assign total    = side * side;
    assign last_pos = pos_x == side - 8'd1 && pos_y == side - 8'd1;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            side      <= '0;
            thrd      <= '0;
            bias_ext  <= '0;
            scale_cnt <= '0;
            shifting  <= 1'b0;
            rd_req    <= 1'b0;
            rd_addr   <= '0;
            pos_x     <= '0;
            pos_y     <= '0;
            ret_cnt   <= '0;
            busy      <= 1'b0;
            last_ret  <= 1'b0;
            done      <= 1'b0;
        end else begin
            last_ret <= 1'b0;
            done     <= last_ret;
            if (start) begin
                side      <= img_size - 8'd2;
                thrd      <= lif_thrd;
                bias_ext  <= {{(snn_pkg::MEM_W - snn_pkg::PSUM_W){bias[snn_pkg::PSUM_W-1]}},
                              bias};
                scale_cnt <= bias_scale;
                // a zero scale skips extension entirely
                shifting  <= bias_scale != 4'd0;
                rd_req    <= bias_scale == 4'd0;
                rd_addr   <= '0;
                pos_x     <= '0;
                pos_y     <= '0;
                ret_cnt   <= '0;
                busy      <= 1'b1;
            end else begin
                if (shifting) begin
                    bias_ext  <= bias_ext << 1;
                    scale_cnt <= scale_cnt - 4'd1;
                    if (scale_cnt == 4'd1) begin
                        shifting <= 1'b0;
                        rd_req   <= 1'b1;
                    end
                end
                // row-major walk, address follows the position
                if (rd_req && rd_gnt) begin
                    rd_addr <= rd_addr + 1'b1;
                    if (last_pos) begin
                        rd_req <= 1'b0;
                    end else if (pos_x == side - 8'd1) begin
                        pos_x <= '0;
                        pos_y <= pos_y + 8'd1;
                    end else begin
                        pos_x <= pos_x + 8'd1;
                    end
                end
                if (rd_data_valid) begin
                    ret_cnt  <= ret_cnt + 16'd1;
                    last_ret <= ret_cnt == total - 16'd1;
                end
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign psum_valid = rd_data_valid;
    assign psum_word  = rd_data;

    a_start_idle: assert property (@(posedge s_clk) disable iff (s_rst) start |-> !busy)
        else $error("start while readback busy");

    a_map_fits: assert property (@(posedge s_clk) disable iff (s_rst) rd_req |-> rd_addr < DEPTH)
        else $error("output map larger than psum ram");

endmodule

/* verilog/psum_ram.sv */
`timescale 1ns/1ns
module psum_ram #(
    parameter int DEPTH = 256
) (
    input  logic                       s_clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [snn_pkg::ADDR_W-1:0] addr,
    input  logic [snn_pkg::WORD_W-1:0] wdata,
    output logic [snn_pkg::WORD_W-1:0] rdata
);

    logic [snn_pkg::WORD_W-1:0] mem [DEPTH];

    // rdata holds its value on writes and idle cycles
    always_ff @(posedge s_clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    a_addr_in_range: assert property (@(posedge s_clk) en |-> addr < DEPTH)
        else $error("psum ram access beyond DEPTH");

endmodule

/* verilog/psum_ram_arbiter.sv */
`timescale 1ns/1ns
module psum_ram_arbiter (
    input  logic                       s_clk,
    input  logic                       s_rst,
    input  logic                       rd_req,
    input  logic [snn_pkg::ADDR_W-1:0] rd_addr,
    output logic                       rd_gnt,
    output logic [snn_pkg::WORD_W-1:0] rd_data,
    output logic                       rd_data_valid,
    input  logic                       host_req,
    input  logic [snn_pkg::ADDR_W-1:0] host_addr,
    input  logic [snn_pkg::WORD_W-1:0] host_wdata,
    output logic                       host_gnt,
    output logic                       en,
    output logic                       we,
    output logic [snn_pkg::ADDR_W-1:0] addr,
    output logic [snn_pkg::WORD_W-1:0] wdata,
    input  logic [snn_pkg::WORD_W-1:0] rdata
);

    // read tag, one stage for the command register and one for the ram
    logic [1:0] rd_tag;

    // readback engine always wins
    assign rd_gnt   = rd_req;
    assign host_gnt = host_req & ~rd_req;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            en     <= 1'b0;
            we     <= 1'b0;
            rd_tag <= 2'b00;
        end else begin
            en     <= rd_gnt | host_gnt;
            we     <= host_gnt;
            rd_tag <= {rd_tag[0], rd_gnt};
        end
    end

    always_ff @(posedge s_clk) begin
        addr  <= rd_gnt ? rd_addr : host_addr;
        wdata <= host_wdata;
    end

    assign rd_data       = rdata;
    assign rd_data_valid = rd_tag[1];

    // a waiting host write keeps its address and data until granted
    a_host_held: assert property (@(posedge s_clk) disable iff (s_rst)
        host_req && !host_gnt |=> host_req && $stable(host_addr) && $stable(host_wdata))
        else $error("host request dropped or changed before grant");

endmodule

/* verilog/snn_pkg.sv */
package snn_pkg;

    localparam int TIME_STEPS = 4;
    localparam int PSUM_W     = 8;
    localparam int WORD_W     = TIME_STEPS * PSUM_W;
    localparam int MEM_W      = 16;
    localparam int ADDR_W     = 8;

    // byte address width of the host port
    localparam int AXI_AW     = 12;

    localparam logic [AXI_AW-1:0] REG_CTRL   = 12'h000;
    localparam logic [AXI_AW-1:0] REG_IMG    = 12'h004;
    localparam logic [AXI_AW-1:0] REG_THRD   = 12'h008;
    localparam logic [AXI_AW-1:0] REG_BIAS   = 12'h00C;
    localparam logic [AXI_AW-1:0] REG_STATUS = 12'h010;

    // psum word i at PSUM_WIN + 4*i
    localparam logic [AXI_AW-1:0] PSUM_WIN   = 12'h400;

endpackage

/* verilog/spike_conv_top.sv */
`timescale 1ns/1ns
module spike_conv_top #(
    parameter int DEPTH = 256
) (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic [snn_pkg::AXI_AW-1:0]     awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [snn_pkg::WORD_W-1:0]     wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [snn_pkg::AXI_AW-1:0]     araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [snn_pkg::WORD_W-1:0]     rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           spike_valid,
    output logic [snn_pkg::TIME_STEPS-1:0] spike_bits,
    output logic                           done
);

    logic                       host_req;
    logic [snn_pkg::ADDR_W-1:0] host_addr;
    logic [snn_pkg::WORD_W-1:0] host_wdata;
    logic                       host_gnt;
    logic                       start;
    logic [7:0]                 img_size;
    logic [snn_pkg::MEM_W-1:0]  lif_thrd;
    logic [snn_pkg::PSUM_W-1:0] bias;
    logic [3:0]                 bias_scale;
    logic                       rd_req;
    logic [snn_pkg::ADDR_W-1:0] rd_addr;
    logic                       rd_gnt;
    logic [snn_pkg::WORD_W-1:0] rd_data;
    logic                       rd_data_valid;
    logic                       ram_en;
    logic                       ram_we;
    logic [snn_pkg::ADDR_W-1:0] ram_addr;
    logic [snn_pkg::WORD_W-1:0] ram_wdata;
    logic [snn_pkg::WORD_W-1:0] ram_rdata;
    logic                       psum_valid;
    logic [snn_pkg::WORD_W-1:0] psum_word;
    logic [snn_pkg::MEM_W-1:0]  bias_ext;
    logic [snn_pkg::MEM_W-1:0]  thrd;

    host_regs #(.DEPTH(DEPTH)) u_host_regs (
        .s_clk(s_clk), .s_rst(s_rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .host_req(host_req), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_gnt(host_gnt), .start(start), .img_size(img_size), .lif_thrd(lif_thrd),
        .bias(bias), .bias_scale(bias_scale), .done(done)
    );

    psum_ram_arbiter u_arbiter (
        .s_clk(s_clk), .s_rst(s_rst),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
        .rd_data(rd_data), .rd_data_valid(rd_data_valid),
        .host_req(host_req), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_gnt(host_gnt),
        .en(ram_en), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    psum_ram #(.DEPTH(DEPTH)) u_psum_ram (
        .s_clk(s_clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    psum_callback #(.DEPTH(DEPTH)) u_psum_callback (
        .s_clk(s_clk), .s_rst(s_rst), .start(start),
        .img_size(img_size), .lif_thrd(lif_thrd), .bias(bias), .bias_scale(bias_scale),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
        .rd_data(rd_data), .rd_data_valid(rd_data_valid),
        .psum_valid(psum_valid), .psum_word(psum_word),
        .bias_ext(bias_ext), .thrd(thrd), .done(done)
    );

    lif_row u_lif_row (
        .s_clk(s_clk), .s_rst(s_rst),
        .psum_valid(psum_valid), .psum_word(psum_word),
        .bias_ext(bias_ext), .thrd(thrd),
        .spike_valid(spike_valid), .spike_bits(spike_bits)
    );

endmodule
